// ==== lut_macros.svh ====
`ifndef LUT_MACROS_SVH
`define LUT_MACROS_SVH

// Symbol width seen on the lookup port
`define LUT_DATA_W 32

// Bus beat and memory word width, two symbols per word
`define LUT_BUS_DATA_W 64

// Word address into the table, top bit picks the ping-pong half
`define LUT_ADDR_W 10

`define LUT_BUS_ADDR_W 32

// Burst length field
`define LUT_LEN_W 8

// Period, duty and iteration counters of the address generator
`define LUT_CNT_W 10

`endif

// ==== lut_pkg.sv ====
`include "lut_macros.svh"

package lut_pkg;

   // One lookup symbol
   typedef logic [`LUT_DATA_W-1:0] sym_t;

   // One memory word, also one bus beat
   typedef logic [`LUT_BUS_DATA_W-1:0] word_t;

   // Table word address
   typedef logic [`LUT_ADDR_W-1:0] addr_t;

   // Address on the external data bus
   typedef logic [`LUT_BUS_ADDR_W-1:0] bus_addr_t;

   // Generator counts and their configuration
   typedef logic [`LUT_CNT_W-1:0] cnt_t;

endpackage

// ==== lut_addr_gen.sv ====
`timescale 1ns/1ps

module lut_addr_gen (
   input  logic           clk,
   input  logic           rst,
   input  logic           start,
   input  lut_pkg::cnt_t  iterations,
   input  lut_pkg::cnt_t  period,
   input  lut_pkg::cnt_t  duty,
   input  lut_pkg::addr_t shift,
   input  lut_pkg::addr_t incr,
   input  logic           addr_take,
   output logic           addr_avail,
   output lut_pkg::addr_t gen_addr,
   output logic           gen_done
);

   logic           busy;
   lut_pkg::cnt_t  per_cnt;
   lut_pkg::cnt_t  iter_cnt;
   lut_pkg::addr_t addr_q;
   logic           in_duty;
   logic           per_last;
   logic           iter_last;
   logic           step;

   // A zero period or iteration count behaves as one
   assign per_last  = (period == '0) || (per_cnt == period - 1'b1);
   assign iter_last = (iterations == '0) || (iter_cnt == iterations - 1'b1);

   assign in_duty = per_cnt < duty;

   // Inside the duty window wait for the consumer, outside it just count
   assign step = busy && (in_duty ? addr_take : 1'b1);

   assign addr_avail = busy && in_duty;
   assign gen_addr   = addr_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy     <= 1'b0;
         per_cnt  <= '0;
         iter_cnt <= '0;
         addr_q   <= '0;
         gen_done <= 1'b0;
      end else if (start) begin
         busy     <= 1'b1;
         per_cnt  <= '0;
         iter_cnt <= '0;
         addr_q   <= '0;
         gen_done <= 1'b0;
      end else if (step) begin
         if (per_last) begin
            per_cnt <= '0;
            // End of period jumps by the shift on top of the normal step
            addr_q  <= addr_q + incr + shift;
            if (iter_last) begin
               busy     <= 1'b0;
               gen_done <= 1'b1;
            end else begin
               iter_cnt <= iter_cnt + 1'b1;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            addr_q  <= addr_q + incr;
         end
      end
   end

endmodule

// ==== lut_mem_writer.sv ====
`timescale 1ns/1ps

module lut_mem_writer (
   input  logic           clk,
   input  logic           rst,
   input  logic           enable,
   input  logic           addr_avail,
   input  lut_pkg::addr_t gen_addr,
   input  logic           data_valid,
   input  lut_pkg::word_t data_in,
   output logic           data_ready,
   output logic           addr_take,
   output logic           mem_we,
   output lut_pkg::addr_t mem_waddr,
   output lut_pkg::word_t mem_wdata
);

   logic beat;

   // Accept a word only when there is somewhere to put it
   assign data_ready = enable && addr_avail;
   assign beat       = data_ready && data_valid;
   assign addr_take  = beat;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mem_we <= 1'b0;
      end else begin
         mem_we <= beat;
      end
   end

   // Address and word for the write issued one cycle after the beat
   always_ff @(posedge clk) begin
      if (beat) begin
         mem_waddr <= gen_addr;
         mem_wdata <= data_in;
      end
   end

endmodule

// ==== lut_dp_ram.sv ====
`timescale 1ns/1ps

module lut_dp_ram #(
   parameter int DEPTH_W = 10,
   parameter int WIDTH_W = 64
) (
   input  logic               clk,
   input  logic [DEPTH_W-1:0] rd_addr,
   output logic [WIDTH_W-1:0] rd_data,
   input  logic               wr_en,
   input  logic [DEPTH_W-1:0] wr_addr,
   input  logic [WIDTH_W-1:0] wr_data
);

   logic [WIDTH_W-1:0] mem [0:(1 << DEPTH_W)-1];

   // Read during write to the same word returns the old contents
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== lut_read.sv ====
`timescale 1ns/1ps

`include "lut_macros.svh"

module lut_read (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  logic                  disabled,
   input  logic                  pingPong,
   input  lut_pkg::bus_addr_t    ext_addr,
   input  logic [`LUT_LEN_W-1:0] length,
   input  lut_pkg::cnt_t         iterations,
   input  lut_pkg::cnt_t         period,
   input  lut_pkg::cnt_t         duty,
   input  lut_pkg::addr_t        shift,
   input  lut_pkg::addr_t        incr,
   input  lut_pkg::sym_t         in0,
   input  lut_pkg::word_t        rd_data,
   input  logic                  databus_ready,
   input  logic                  databus_last,
   input  lut_pkg::word_t        databus_rdata,
   output logic                  databus_valid,
   output lut_pkg::bus_addr_t    databus_addr,
   output logic [`LUT_LEN_W-1:0] databus_len,
   output logic                  done,
   output lut_pkg::sym_t         out0,
   output lut_pkg::addr_t        rd_addr,
   output logic                  wr_en,
   output lut_pkg::addr_t        wr_addr,
   output lut_pkg::word_t        wr_data
);

   logic           start;
   logic           last_beat;
   logic           pp_state;
   logic           load_en;
   lut_pkg::addr_t rd_addr_next;
   logic           sel_0;
   logic           sel_1;
   logic           addr_avail;
   logic           addr_take;
   lut_pkg::addr_t gen_addr;
   logic           gen_done;
   logic           mem_we;
   lut_pkg::addr_t mem_waddr;
   lut_pkg::word_t mem_wdata;

   assign start     = run && !disabled;
   assign last_beat = databus_valid && databus_ready && databus_last;

   assign databus_len = length;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done         <= 1'b1;
         load_en      <= 1'b0;
         databus_addr <= '0;
      end else if (start) begin
         done         <= 1'b0;
         load_en      <= 1'b1;
         databus_addr <= ext_addr;
      end else if (last_beat) begin
         done    <= 1'b1;
         load_en <= 1'b0;
      end
   end

   // Halves swap on every run in ping-pong mode
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (start) begin
         pp_state <= pingPong ? !pp_state : 1'b0;
      end
   end

   lut_addr_gen addr_gen_i (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .iterations (iterations),
      .period     (period),
      .duty       (duty),
      .shift      (shift),
      .incr       (incr),
      .addr_take  (addr_take),
      .addr_avail (addr_avail),
      .gen_addr   (gen_addr),
      .gen_done   (gen_done)
   );

   // Bus naming is inverted, the unit raises valid when it can accept
   lut_mem_writer mem_writer_i (
      .clk        (clk),
      .rst        (rst),
      .enable     (load_en && !gen_done),
      .addr_avail (addr_avail),
      .gen_addr   (gen_addr),
      .data_valid (databus_ready),
      .data_in    (databus_rdata),
      .data_ready (databus_valid),
      .addr_take  (addr_take),
      .mem_we     (mem_we),
      .mem_waddr  (mem_waddr),
      .mem_wdata  (mem_wdata)
   );

   // Loading goes to the half not being read
   assign wr_addr = pingPong ?
                    {pp_state ^ mem_waddr[`LUT_ADDR_W-1], mem_waddr[`LUT_ADDR_W-2:0]} :
                    mem_waddr;
   assign wr_en   = mem_we;
   assign wr_data = mem_wdata;

   // Symbol index to word address, lane bit dropped
   always_comb begin
      rd_addr_next = lut_pkg::addr_t'(in0 >> 1);
      rd_addr_next[`LUT_ADDR_W-1] = pingPong && !pp_state;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
         sel_0   <= 1'b0;
         sel_1   <= 1'b0;
      end else begin
         rd_addr <= rd_addr_next;
         sel_0   <= in0[0];
         sel_1   <= sel_0;
      end
   end

   // sel_1 lines up with the registered memory output
   assign out0 = sel_1 ? rd_data[`LUT_BUS_DATA_W-1 -: `LUT_DATA_W] :
                         rd_data[`LUT_DATA_W-1:0];

endmodule

// ==== lut_top.sv ====
`timescale 1ns/1ps

`include "lut_macros.svh"

module lut_top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  logic                  disabled,
   input  logic                  pingPong,
   input  lut_pkg::bus_addr_t    ext_addr,
   input  logic [`LUT_LEN_W-1:0] length,
   input  lut_pkg::cnt_t         iterations,
   input  lut_pkg::cnt_t         period,
   input  lut_pkg::cnt_t         duty,
   input  lut_pkg::addr_t        shift,
   input  lut_pkg::addr_t        incr,
   input  lut_pkg::sym_t         in0,
   input  logic                  databus_ready,
   input  logic                  databus_last,
   input  lut_pkg::word_t        databus_rdata,
   output logic                  databus_valid,
   output lut_pkg::bus_addr_t    databus_addr,
   output logic [`LUT_LEN_W-1:0] databus_len,
   output logic                  done,
   output lut_pkg::sym_t         out0
);

   lut_pkg::addr_t rd_addr;
   lut_pkg::word_t rd_data;
   logic           wr_en;
   lut_pkg::addr_t wr_addr;
   lut_pkg::word_t wr_data;

   lut_read lut_read_i (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .disabled      (disabled),
      .pingPong      (pingPong),
      .ext_addr      (ext_addr),
      .length        (length),
      .iterations    (iterations),
      .period        (period),
      .duty          (duty),
      .shift         (shift),
      .incr          (incr),
      .in0           (in0),
      .rd_data       (rd_data),
      .databus_ready (databus_ready),
      .databus_last  (databus_last),
      .databus_rdata (databus_rdata),
      .databus_valid (databus_valid),
      .databus_addr  (databus_addr),
      .databus_len   (databus_len),
      .done          (done),
      .out0          (out0),
      .rd_addr       (rd_addr),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data)
   );

   // Table storage, both ping-pong halves
   lut_dp_ram #(
      .DEPTH_W (`LUT_ADDR_W),
      .WIDTH_W (`LUT_BUS_DATA_W)
   ) lut_dp_ram_i (
      .clk     (clk),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data)
   );

endmodule

// ==== tb_lut_top.sv ====
`timescale 1ns/1ps

`include "lut_macros.svh"

module tb_lut_top;

   logic                  clk;
   logic                  rst;
   logic                  run;
   logic                  disabled;
   logic                  pingPong;
   lut_pkg::bus_addr_t    ext_addr;
   logic [`LUT_LEN_W-1:0] length;
   lut_pkg::cnt_t         iterations;
   lut_pkg::cnt_t         period;
   lut_pkg::cnt_t         duty;
   lut_pkg::addr_t        shift;
   lut_pkg::addr_t        incr;
   lut_pkg::sym_t         in0;
   logic                  databus_ready;
   logic                  databus_last;
   lut_pkg::word_t        databus_rdata;
   logic                  databus_valid;
   lut_pkg::bus_addr_t    databus_addr;
   logic [`LUT_LEN_W-1:0] databus_len;
   logic                  done;
   lut_pkg::sym_t         out0;

   // Reference copy of the whole memory, both halves
   lut_pkg::word_t model_mem [0:(1 << `LUT_ADDR_W)-1];
   lut_pkg::addr_t exp_addr [$];
   logic           pp_mode;
   logic           model_pp;
   integer         seed;

   lut_top lut_top_i (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .disabled      (disabled),
      .pingPong      (pingPong),
      .ext_addr      (ext_addr),
      .length        (length),
      .iterations    (iterations),
      .period        (period),
      .duty          (duty),
      .shift         (shift),
      .incr          (incr),
      .in0           (in0),
      .databus_ready (databus_ready),
      .databus_last  (databus_last),
      .databus_rdata (databus_rdata),
      .databus_valid (databus_valid),
      .databus_addr  (databus_addr),
      .databus_len   (databus_len),
      .done          (done),
      .out0          (out0)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (expected !== actual) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         $display("SIMULATION FAILED");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s did not finish in time", what);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout in %s", what);
   endtask

   function automatic int pick_gap(input int stall_max);
      if (stall_max > 0) begin
         pick_gap = int'($unsigned($random(seed)) % stall_max);
      end else begin
         pick_gap = 0;
      end
   endfunction

   // Symbol the table should return for an index under the current half selection
   function automatic lut_pkg::sym_t expected_symbol(input int idx);
      lut_pkg::addr_t word_a;
      lut_pkg::word_t w;
      word_a = {pp_mode && !model_pp, idx[`LUT_ADDR_W-1:1]};
      w = model_mem[word_a];
      expected_symbol = idx[0] ? w[63:32] : w[31:0];
   endfunction

   // Write addresses in the order the generator should offer them
   task automatic plan_addresses(input int iters, input int per, input int dty,
                                 input int shf, input int inc);
      int i;
      int p;
      exp_addr.delete();
      for (i = 0; i < iters; i++) begin
         for (p = 0; p < per; p++) begin
            if (p < dty) begin
               exp_addr.push_back(lut_pkg::addr_t'(i * (per * inc + shf) + p * inc));
            end
         end
      end
   endtask

   task automatic start_run(input string name, input logic pp, input int iters, input int per,
                            input int dty, input int shf, input int inc,
                            input lut_pkg::bus_addr_t base, output int beats);
      plan_addresses(iters, per, dty, shf, inc);
      beats = exp_addr.size();
      @(posedge clk);
      pingPong   <= pp;
      ext_addr   <= base;
      length     <= `LUT_LEN_W'(beats);
      iterations <= lut_pkg::cnt_t'(iters);
      period     <= lut_pkg::cnt_t'(per);
      duty       <= lut_pkg::cnt_t'(dty);
      shift      <= lut_pkg::addr_t'(shf);
      incr       <= lut_pkg::addr_t'(inc);
      run        <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      pp_mode  = pp;
      model_pp = pp ? !model_pp : 1'b0;
      @(negedge clk);
      compare({name, " done after run"}, 64'(1'b0), 64'(done));
      compare({name, " bus address"}, 64'(base), 64'(databus_addr));
      compare({name, " bus length"}, 64'(beats), 64'(databus_len));
   endtask

   // Bus source, stalls come from the seeded random sequence
   task automatic feed_burst(input string name, input int n, input int stall_max,
                             input logic check_bp);
      int             sent;
      int             gap;
      int             cycles;
      lut_pkg::word_t cur;
      lut_pkg::addr_t a;
      lut_pkg::addr_t phys;
      sent   = 0;
      cycles = 0;
      gap    = pick_gap(stall_max);
      cur    = {$random(seed), $random(seed)};
      while (sent < n) begin
         @(posedge clk);
         if (gap > 0) begin
            databus_ready <= 1'b0;
            databus_last  <= 1'b0;
            gap = gap - 1;
         end else begin
            databus_ready <= 1'b1;
            databus_rdata <= cur;
            databus_last  <= (sent == n - 1);
         end
         @(negedge clk);
         compare({name, " done during load"}, 64'(1'b0), 64'(done));
         if (databus_ready && databus_valid) begin
            // Beat transfers on the next rising edge
            a    = exp_addr.pop_front();
            phys = pp_mode ? {model_pp ^ a[`LUT_ADDR_W-1], a[`LUT_ADDR_W-2:0]} : a;
            model_mem[phys] = cur;
            sent = sent + 1;
            cur  = {$random(seed), $random(seed)};
            gap  = pick_gap(stall_max);
         end else if (!databus_ready && check_bp) begin
            compare({name, " valid held in stall"}, 64'(1'b1), 64'(databus_valid));
         end
         cycles = cycles + 1;
         if (cycles > 4000) begin
            report_timeout(name);
         end
      end
      @(posedge clk);
      databus_ready <= 1'b0;
      databus_last  <= 1'b0;
      @(negedge clk);
      compare({name, " done on last beat"}, 64'(1'b1), 64'(done));
      compare({name, " valid after last"}, 64'(1'b0), 64'(databus_valid));
   endtask

   // One index per cycle, each result checked two edges later
   task automatic lookup_range(input string name, input int first, input int count);
      lut_pkg::sym_t exp_q [$];
      int            i;
      for (i = 0; i < count + 2; i++) begin
         @(posedge clk);
         if (i < count) begin
            in0 <= lut_pkg::sym_t'(first + i);
            exp_q.push_back(expected_symbol(first + i));
         end
         @(negedge clk);
         if (i >= 2) begin
            compare($sformatf("%s index %0d", name, first + i - 2),
                    64'(exp_q.pop_front()), 64'(out0));
         end
      end
   endtask

   task automatic run_disabled(input string name);
      int k;
      @(posedge clk);
      disabled <= 1'b1;
      run      <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      for (k = 0; k < 10; k++) begin
         @(negedge clk);
         compare({name, " done"}, 64'(1'b1), 64'(done));
         compare({name, " valid"}, 64'(1'b0), 64'(databus_valid));
      end
      @(posedge clk);
      disabled <= 1'b0;
   endtask

   initial begin
      int beats;
      seed     = 32'hed5a_a6f9;
      pp_mode  = 1'b0;
      model_pp = 1'b0;
      rst           <= 1'b1;
      run           <= 1'b0;
      disabled      <= 1'b0;
      pingPong      <= 1'b0;
      ext_addr      <= '0;
      length        <= '0;
      iterations    <= '0;
      period        <= '0;
      duty          <= '0;
      shift         <= '0;
      incr          <= '0;
      in0           <= '0;
      databus_ready <= 1'b0;
      databus_last  <= 1'b0;
      databus_rdata <= '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      compare("reset done", 64'(1'b1), 64'(done));
      compare("reset valid", 64'(1'b0), 64'(databus_valid));
      compare("reset bus address", 64'(0), 64'(databus_addr));

      // Dense table of 64 words
      start_run("dense", 1'b0, 4, 16, 16, 0, 1, 32'h8000_1000, beats);
      feed_burst("dense", beats, 3, 1'b0);
      lookup_range("dense read", 0, 128);

      // Strided overwrite, other words keep the dense contents
      start_run("strided", 1'b0, 5, 4, 2, 3, 2, 32'h0000_2400, beats);
      feed_burst("strided", beats, 3, 1'b0);
      lookup_range("strided read", 0, 128);

      start_run("stall", 1'b0, 4, 16, 16, 0, 1, 32'h1234_5678, beats);
      feed_burst("stall", beats, 9, 1'b1);
      lookup_range("stall read", 0, 128);

      // Ping-pong, a table becomes readable from the following run
      start_run("pingpong a", 1'b1, 4, 16, 16, 0, 1, 32'h0000_a000, beats);
      feed_burst("pingpong a", beats, 3, 1'b0);
      lookup_range("pingpong after a", 0, 128);
      start_run("pingpong b", 1'b1, 4, 16, 16, 0, 1, 32'h0000_b000, beats);
      fork
         feed_burst("pingpong b", beats, 4, 1'b0);
         lookup_range("read during b", 0, 128);
      join
      lookup_range("read after b", 0, 128);
      start_run("pingpong c", 1'b1, 2, 8, 8, 0, 1, 32'h0000_c000, beats);
      fork
         feed_burst("pingpong c", beats, 4, 1'b0);
         lookup_range("read during c", 0, 128);
      join
      lookup_range("read after c", 0, 128);

      run_disabled("disabled run");
      lookup_range("read after disabled", 0, 128);

      repeat (2) @(posedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+.
lut_pkg.sv
lut_addr_gen.sv
lut_mem_writer.sv
lut_dp_ram.sv
lut_read.sv
lut_top.sv
tb_lut_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
   --top-module tb_lut_top -o tb_lut_top

out=$(./obj_dir/tb_lut_top 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
   exit 0
else
   exit 1
fi
